//--- Makefile
VERILATOR  ?= verilator
TOP        := batch_tb
FILELIST   := src.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only --timing
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/batch_assertions.sv
`include "batch_macros.svh"

module batch_assertions (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        s_ready,
    input logic                        m_valid,
    input logic                        m_ready,
    input logic [`BATCH_ID_WIDTH-1:0]  m_owner_program_id,
    input logic [`BATCH_DEP_WIDTH-1:0] m_read_deps,
    input logic [`BATCH_DEP_WIDTH-1:0] m_write_deps,
    input logic                        batch_completed
);

    // Number of failed properties so far
    int fail_count = 0;

    // Collect and replay phases never overlap
    ready_valid_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(s_ready && m_valid)
    ) else begin
        $error("s_ready and m_valid are high together");
        fail_count++;
    end

    // A back-pressured beat keeps its data
    output_held_on_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_owner_program_id) &&
                                   $stable(m_read_deps) && $stable(m_write_deps))
    ) else begin
        $error("output changed while m_ready was low");
        fail_count++;
    end

    completion_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) batch_completed |=> !batch_completed
    ) else begin
        $error("batch_completed stayed high for two cycles");
        fail_count++;
    end

endmodule

//--- sim/batch_checker.sv
`include "batch_macros.svh"

module batch_checker (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         s_valid,
    input logic                         s_ready,
    input logic [`BATCH_ID_WIDTH-1:0]   s_owner_program_id,
    input logic [`BATCH_DEP_WIDTH-1:0]  s_read_deps,
    input logic [`BATCH_DEP_WIDTH-1:0]  s_write_deps,
    input logic                         m_valid,
    input logic                         m_ready,
    input logic [`BATCH_ID_WIDTH-1:0]   m_owner_program_id,
    input logic [`BATCH_DEP_WIDTH-1:0]  m_read_deps,
    input logic [`BATCH_DEP_WIDTH-1:0]  m_write_deps,
    input logic                         batch_completed,
    input logic [`BATCH_STAT_WIDTH-1:0] transactions_batched,
    input logic [`BATCH_STAT_WIDTH-1:0] batch_stall_count
);

    // Accepted inputs waiting for delivery in arrival order
    batch_pkg::txn_t model_q [$];
    int              sizes_q [$];

    batch_pkg::txn_t in_txn;
    batch_pkg::txn_t out_txn;
    batch_pkg::txn_t prev_out;
    batch_pkg::txn_t exp_txn;

    string test_name = "reset";
    int    cycle = 0;
    int    last_accept = 0;
    int    batch_fill = 0;
    int    beats_in_batch = 0;
    int    batches_done = 0;
    int    batch_base = 0;
    int    run_errors = 0;
    int    run_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    total_errors = 0;
    logic  valid_prev = 1'b0;
    logic  stall_prev = 1'b0;
    logic  beat_prev = 1'b0;
    logic  done_prev = 1'b0;
    logic [`BATCH_STAT_WIDTH-1:0] stall_base = '0;

    assign in_txn  = {s_owner_program_id, s_read_deps, s_write_deps};
    assign out_txn = {m_owner_program_id, m_read_deps, m_write_deps};

    task automatic report_mismatch(string what, string exp, string act);
        $display("** Error %s: %s expected %s actual %s", test_name, what, exp, act);
    endtask

    task automatic report_problem(string msg);
        $display("Error in %s: %s", test_name, msg);
    endtask

    // Partial batches wait out exactly one idle timeout before the first beat
    task automatic check_gap();
        int limit;
        int gap;
        gap = cycle - last_accept;
        if (batch_fill < `BATCH_MAX_SIZE) begin
            limit = (batch_fill < `BATCH_MIN_SIZE) ? 2 * `BATCH_TIMEOUT_CYCLES
                                                   : `BATCH_TIMEOUT_CYCLES;
            // Restart edge, limit idle cycles, then the closing edge
            if (gap <= limit || gap > limit + 2) begin
                report_mismatch("idle cycles before output",
                                $sformatf("%0d to %0d", limit + 1, limit + 2),
                                $sformatf("%0d", gap));
                run_errors++;
            end
        end
    endtask

    // Sampled mid-cycle while all DUT outputs are stable
    always @(negedge clk) begin
        if (rst_n) begin
            cycle++;
            if (batch_completed) begin
                if (done_prev || !beat_prev) begin
                    report_problem("batch_completed was not a single pulse after the last beat");
                    run_errors++;
                end
                sizes_q.push_back(beats_in_batch);
                batches_done++;
                beats_in_batch = 0;
                batch_fill = 0;
            end
            if (s_valid && s_ready) begin
                if (m_valid) begin
                    report_problem("an input was accepted while output was valid");
                    run_errors++;
                end
                model_q.push_back(in_txn);
                batch_fill++;
                last_accept = cycle;
            end
            if (m_valid && !valid_prev) begin
                check_gap();
            end
            if (m_valid && stall_prev && out_txn != prev_out) begin
                report_mismatch("held output", $sformatf("%h", prev_out), $sformatf("%h", out_txn));
                run_errors++;
            end
            if (m_valid && m_ready) begin
                if (model_q.size() == 0) begin
                    report_problem("an output beat appeared with no accepted input");
                    run_errors++;
                end else begin
                    exp_txn = model_q.pop_front();
                    if (exp_txn != out_txn) begin
                        report_mismatch($sformatf("beat %0d", beats_in_batch),
                                        $sformatf("%h", exp_txn), $sformatf("%h", out_txn));
                        run_errors++;
                    end
                end
                beats_in_batch++;
            end
            valid_prev = m_valid;
            stall_prev = m_valid && !m_ready;
            beat_prev  = m_valid && m_ready;
            done_prev  = batch_completed;
            prev_out   = out_txn;
        end
    end

    task automatic begin_test(string name);
        test_name = name;
    endtask

    task automatic finish_test(int exp_n, int size0, int size1, int exp_inc, int exp_total,
                               bit timed_out);
        int bad;
        int exp_size;
        int test_errors;
        bad = 0;
        if (timed_out) begin
            report_problem("a wait timed out");
            bad++;
        end
        if (batches_done - batch_base != exp_n) begin
            report_mismatch("batch count", $sformatf("%0d", exp_n),
                            $sformatf("%0d", batches_done - batch_base));
            bad++;
        end else begin
            for (int k = 0; k < exp_n; k++) begin
                exp_size = (k == 0) ? size0 : size1;
                if (sizes_q[batch_base + k] != exp_size) begin
                    report_mismatch($sformatf("size of batch %0d", k), $sformatf("%0d", exp_size),
                                    $sformatf("%0d", sizes_q[batch_base + k]));
                    bad++;
                end
            end
        end
        if (model_q.size() != 0) begin
            report_problem("accepted transactions were never delivered");
            bad++;
        end
        if (transactions_batched != `BATCH_STAT_WIDTH'(exp_total)) begin
            report_mismatch("transactions_batched", $sformatf("%0d", exp_total),
                            $sformatf("%0d", transactions_batched));
            bad++;
        end
        if (batch_stall_count - stall_base != `BATCH_STAT_WIDTH'(exp_inc)) begin
            report_mismatch("batch_stall_count increment", $sformatf("%0d", exp_inc),
                            $sformatf("%0d", batch_stall_count - stall_base));
            bad++;
        end
        test_errors = run_errors - run_base + bad;
        total_errors += test_errors;
        tests_run++;
        if (test_errors == 0) begin
            $display("ok      %s", test_name);
        end else begin
            tests_failed++;
            $display("failed  %s (%0d errors)", test_name, test_errors);
        end
        run_base   = run_errors;
        batch_base = batches_done;
        stall_base = batch_stall_count;
    endtask

    task automatic report_counts(int assert_fails);
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors,
                 assert_fails);
    endtask

endmodule

//--- sim/batch_tb.sv
`include "batch_macros.svh"

module batch_tb;

    localparam int NUM_TESTS  = 6;
    localparam int WAIT_LIMIT = 200;

    typedef struct {
        string name;
        int    num_txn;
        int    stall_len;
        int    stall_beat;
        int    exp_batches;
        int    exp_size0;
        int    exp_size1;
        int    exp_stall_inc;
    } test_row_t;

    logic                         clk;
    logic                         rst_n;
    logic                         s_valid;
    logic                         s_ready;
    logic [`BATCH_ID_WIDTH-1:0]   s_owner_program_id;
    logic [`BATCH_DEP_WIDTH-1:0]  s_read_deps;
    logic [`BATCH_DEP_WIDTH-1:0]  s_write_deps;
    logic                         m_valid;
    logic                         m_ready;
    logic [`BATCH_ID_WIDTH-1:0]   m_owner_program_id;
    logic [`BATCH_DEP_WIDTH-1:0]  m_read_deps;
    logic [`BATCH_DEP_WIDTH-1:0]  m_write_deps;
    logic                         batch_completed;
    logic [`BATCH_STAT_WIDTH-1:0] transactions_batched;
    logic [`BATCH_STAT_WIDTH-1:0] batch_stall_count;

    test_row_t rows [NUM_TESTS];
    int        seed = 52;
    int        expected_total = 0;
    bit        timed_out = 1'b0;

    batch_top batch_top_i (.*);

    batch_checker checker_i (.*);

    bind batch_top batch_assertions assertions_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .s_ready            (s_ready),
        .m_valid            (m_valid),
        .m_ready            (m_ready),
        .m_owner_program_id (m_owner_program_id),
        .m_read_deps        (m_read_deps),
        .m_write_deps       (m_write_deps),
        .batch_completed    (batch_completed)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic void set_row(int idx, string name, int num_txn, int stall_len,
                                    int stall_beat, int batches, int size0, int size1, int inc);
        rows[idx].name          = name;
        rows[idx].num_txn       = num_txn;
        rows[idx].stall_len     = stall_len;
        rows[idx].stall_beat    = stall_beat;
        rows[idx].exp_batches   = batches;
        rows[idx].exp_size0     = size0;
        rows[idx].exp_size1     = size1;
        rows[idx].exp_stall_inc = inc;
    endfunction

    // Offer one random transaction and hold it until the edge that accepts it
    task automatic send_txn();
        int waited;
        waited = 0;
        s_valid            <= 1'b1;
        s_owner_program_id <= {$random(seed), $random(seed)};
        s_read_deps        <= `BATCH_DEP_WIDTH'($random(seed));
        s_write_deps       <= `BATCH_DEP_WIDTH'($random(seed));
        @(negedge clk);
        while (!s_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!s_ready) begin
            $display("Timeout: input not accepted within %0d cycles", WAIT_LIMIT);
            timed_out = 1'b1;
        end
        @(posedge clk);
    endtask

    // Drop m_ready for stall_len cycles starting at beat stall_beat
    task automatic drive_ready(int stall_len, int stall_beat);
        int beats;
        int waited;
        beats  = 0;
        waited = 0;
        if (stall_len > 0) begin
            while (beats < stall_beat && waited < WAIT_LIMIT) begin
                @(negedge clk);
                if (m_valid && m_ready) begin
                    beats++;
                end
                waited++;
            end
            if (beats < stall_beat) begin
                $display("Timeout: output beat %0d never arrived", stall_beat);
                timed_out = 1'b1;
            end
            @(posedge clk);
            m_ready <= 1'b0;
            repeat (stall_len) @(posedge clk);
            m_ready <= 1'b1;
        end
    endtask

    task automatic wait_batches(int count);
        int waited;
        waited = 0;
        @(negedge clk);
        while (checker_i.batches_done - checker_i.batch_base < count && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (checker_i.batches_done - checker_i.batch_base < count) begin
            $display("Timeout: expected %0d completed batches, none more arrived", count);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst_n              <= 1'b0;
        s_valid            <= 1'b0;
        s_owner_program_id <= '0;
        s_read_deps        <= '0;
        s_write_deps       <= '0;
        m_ready            <= 1'b1;

        set_row(0, "full_batch",       8,  0, 0, 1, 8, 0, 0);
        set_row(1, "normal_timeout",   3,  0, 0, 1, 3, 0, 0);
        set_row(2, "extended_timeout", 1,  0, 0, 1, 1, 0, 0);
        set_row(3, "overflow",         11, 0, 0, 2, 8, 3, 0);
        set_row(4, "long_stall",       8, 20, 3, 1, 8, 0, 1);
        set_row(5, "short_stall",      8,  5, 3, 1, 8, 0, 0);

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < NUM_TESTS; i++) begin
            @(negedge clk);
            checker_i.begin_test(rows[i].name);
            timed_out = 1'b0;
            @(posedge clk);
            fork
                begin
                    for (int n = 0; n < rows[i].num_txn; n++) begin
                        send_txn();
                    end
                    s_valid <= 1'b0;
                end
                drive_ready(rows[i].stall_len, rows[i].stall_beat);
            join
            expected_total += rows[i].num_txn;
            wait_batches(rows[i].exp_batches);
            checker_i.finish_test(rows[i].exp_batches, rows[i].exp_size0, rows[i].exp_size1,
                                  rows[i].exp_stall_inc, expected_total, timed_out);
        end

        checker_i.report_counts(batch_top_i.assertions_i.fail_count);
        if (checker_i.tests_failed == 0 && batch_top_i.assertions_i.fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/batch_pkg.sv
verilog/batch_buf_if.sv
verilog/batch_buffer.sv
verilog/batch_control.sv
verilog/batch_stats.sv
verilog/batch_top.sv
sim/batch_assertions.sv
sim/batch_checker.sv
sim/batch_tb.sv

//--- verilog/batch_buf_if.sv
`include "batch_macros.svh"

interface batch_buf_if;

    // Write side strobes from the controller
    logic              push;
    batch_pkg::txn_t   push_txn;
    logic              pop;
    logic              clear;

    // Buffer status
    logic [`BATCH_COUNT_WIDTH-1:0] count;
    batch_pkg::txn_t               head_txn;
    // Read index sits on the final stored entry
    logic                          last;

    modport ctrl (
        output push,
        output push_txn,
        output pop,
        output clear,
        input  count,
        input  last
    );

    // Storage side
    modport buffer (
        input  push,
        input  push_txn,
        input  pop,
        input  clear,
        output count,
        output head_txn,
        output last
    );

endinterface

//--- verilog/batch_buffer.sv
`include "batch_macros.svh"

module batch_buffer (
    input logic         clk,
    input logic         rst_n,
    batch_buf_if.buffer buf_port
);

    localparam int CW = `BATCH_COUNT_WIDTH;
    // Address bits for BATCH_MAX_SIZE entries
    localparam int AW = CW - 1;

    batch_pkg::txn_t entries [0:`BATCH_MAX_SIZE-1];

    logic [CW-1:0] wr_count;
    logic [CW-1:0] rd_idx;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr;

    assign wr_addr = wr_count[AW-1:0];
    assign rd_addr = rd_idx[AW-1:0];

    // Entry storage, written at the current count
    always_ff @(posedge clk) begin
        if (buf_port.push) begin
            entries[wr_addr] <= buf_port.push_txn;
        end
    end

    // Write count and read index
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_count <= '0;
            rd_idx   <= '0;
        end else if (buf_port.clear) begin
            wr_count <= '0;
            rd_idx   <= '0;
        end else begin
            if (buf_port.push) begin
                wr_count <= wr_count + 1'b1;
            end
            if (buf_port.pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
        end
    end

    assign buf_port.count    = wr_count;
    assign buf_port.head_txn = entries[rd_addr];
    // Empty buffer never reports last
    assign buf_port.last     = (wr_count != '0) && (rd_idx + 1'b1 == wr_count);

endmodule

//--- verilog/batch_control.sv
`include "batch_macros.svh"

module batch_control (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            s_valid,
    input  batch_pkg::txn_t s_txn,
    output logic            s_ready,
    output logic            m_valid,
    input  logic            m_ready,
    output logic            batch_completed,
    batch_buf_if.ctrl       buf_port
);

    localparam int CW = `BATCH_COUNT_WIDTH;
    // Idle counter must reach the extended limit
    localparam int IW = $clog2(2 * `BATCH_TIMEOUT_CYCLES + 1);

    localparam logic [IW-1:0] NORMAL_LIMIT   = IW'(`BATCH_TIMEOUT_CYCLES);
    localparam logic [IW-1:0] EXTENDED_LIMIT = IW'(2 * `BATCH_TIMEOUT_CYCLES);
    localparam logic [CW-1:0] MAX_COUNT      = CW'(`BATCH_MAX_SIZE);
    localparam logic [CW-1:0] MIN_COUNT      = CW'(`BATCH_MIN_SIZE);

    batch_pkg::batch_state_e state;

    logic          accept;
    logic          beat;
    logic          fill;
    logic          timeout_hit;
    logic [IW-1:0] idle_cnt;

    // Input open while collecting and not full
    assign s_ready = (state == batch_pkg::IDLE) ||
                     ((state == batch_pkg::COLLECT) && (buf_port.count < MAX_COUNT));
    assign m_valid = (state == batch_pkg::OUTPUT);

    assign accept = s_valid && s_ready;
    assign beat   = m_valid && m_ready;

    // This accept takes the last free slot
    assign fill = accept && (buf_port.count == MAX_COUNT - 1'b1);

    // Small batches wait twice as long
    always_comb begin
        if (buf_port.count >= MIN_COUNT) begin
            timeout_hit = (idle_cnt == NORMAL_LIMIT);
        end else begin
            timeout_hit = (idle_cnt == EXTENDED_LIMIT);
        end
    end

    assign buf_port.push     = accept;
    assign buf_port.push_txn = s_txn;
    assign buf_port.pop      = beat;
    assign buf_port.clear    = beat && buf_port.last;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state           <= batch_pkg::IDLE;
            idle_cnt        <= '0;
            batch_completed <= 1'b0;
        end else begin
            batch_completed <= beat && buf_port.last;

            case (state)
                batch_pkg::IDLE: begin
                    idle_cnt <= '0;
                    if (accept) begin
                        state <= batch_pkg::COLLECT;
                    end
                end

                batch_pkg::COLLECT: begin
                    if (accept) begin
                        // Every arrival restarts the idle count
                        idle_cnt <= '0;
                        if (fill) begin
                            state <= batch_pkg::OUTPUT;
                        end
                    end else if (timeout_hit) begin
                        idle_cnt <= '0;
                        state    <= batch_pkg::OUTPUT;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end

                batch_pkg::OUTPUT: begin
                    // No timeout here, wait out back-pressure
                    if (beat && buf_port.last) begin
                        state <= batch_pkg::IDLE;
                    end
                end

                default: begin
                    state <= batch_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/batch_macros.svh
`ifndef BATCH_MACROS_SVH
`define BATCH_MACROS_SVH

// Transaction field widths
`define BATCH_ID_WIDTH 64
`define BATCH_DEP_WIDTH 16

// Batch geometry
`define BATCH_MAX_SIZE 8
// Holds 0..BATCH_MAX_SIZE inclusive
`define BATCH_COUNT_WIDTH 4
`define BATCH_MIN_SIZE 2

// Idle cycles before a batch with enough entries is closed
`define BATCH_TIMEOUT_CYCLES 20

// Consecutive back-pressured cycles that mark a batch as stalled
`define BATCH_STALL_LIMIT 12

// Statistics counters
`define BATCH_STAT_WIDTH 32

`endif

//--- verilog/batch_pkg.sv
`include "batch_macros.svh"

package batch_pkg;

    // One queued transaction, owner ID in the upper bits
    typedef struct packed {
        logic [`BATCH_ID_WIDTH-1:0]  owner_program_id;
        logic [`BATCH_DEP_WIDTH-1:0] read_deps;
        logic [`BATCH_DEP_WIDTH-1:0] write_deps;
    } txn_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        COLLECT = 2'b01,
        OUTPUT  = 2'b10
    } batch_state_e;

endpackage

//--- verilog/batch_stats.sv
`include "batch_macros.svh"

module batch_stats (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         m_valid,
    input  logic                         m_ready,
    input  logic                         batch_completed,
    output logic [`BATCH_STAT_WIDTH-1:0] transactions_batched,
    output logic [`BATCH_STAT_WIDTH-1:0] batch_stall_count
);

    localparam int RW = $clog2(`BATCH_STALL_LIMIT + 1);

    localparam logic [RW-1:0] RUN_LIMIT = RW'(`BATCH_STALL_LIMIT);

    logic          stalled;
    logic [RW-1:0] stall_run;
    // Current batch already counted as stalled
    logic          stall_seen;

    assign stalled = m_valid && !m_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            transactions_batched <= '0;
            batch_stall_count    <= '0;
            stall_run            <= '0;
            stall_seen           <= 1'b0;
        end else begin
            if (m_valid && m_ready) begin
                transactions_batched <= transactions_batched + 1'b1;
            end

            if (stalled) begin
                // Saturate so long stalls do not wrap
                if (stall_run != RUN_LIMIT) begin
                    stall_run <= stall_run + 1'b1;
                end
            end else begin
                stall_run <= '0;
            end

            if (batch_completed) begin
                stall_seen <= 1'b0;
            end else if (stalled && !stall_seen && (stall_run == RUN_LIMIT - 1'b1)) begin
                stall_seen        <= 1'b1;
                batch_stall_count <= batch_stall_count + 1'b1;
            end
        end
    end

endmodule

//--- verilog/batch_top.sv
`include "batch_macros.svh"

module batch_top (
    input  logic                         clk,
    input  logic                         rst_n,

    // Input stream
    input  logic                         s_valid,
    output logic                         s_ready,
    input  logic [`BATCH_ID_WIDTH-1:0]   s_owner_program_id,
    input  logic [`BATCH_DEP_WIDTH-1:0]  s_read_deps,
    input  logic [`BATCH_DEP_WIDTH-1:0]  s_write_deps,

    // Output stream
    output logic                         m_valid,
    input  logic                         m_ready,
    output logic [`BATCH_ID_WIDTH-1:0]   m_owner_program_id,
    output logic [`BATCH_DEP_WIDTH-1:0]  m_read_deps,
    output logic [`BATCH_DEP_WIDTH-1:0]  m_write_deps,

    output logic                         batch_completed,
    output logic [`BATCH_STAT_WIDTH-1:0] transactions_batched,
    output logic [`BATCH_STAT_WIDTH-1:0] batch_stall_count
);

    batch_pkg::txn_t s_txn;

    batch_buf_if buf_bus ();

    // Pack input fields, unpack the head entry
    assign s_txn.owner_program_id = s_owner_program_id;
    assign s_txn.read_deps        = s_read_deps;
    assign s_txn.write_deps       = s_write_deps;

    assign m_owner_program_id = buf_bus.head_txn.owner_program_id;
    assign m_read_deps        = buf_bus.head_txn.read_deps;
    assign m_write_deps       = buf_bus.head_txn.write_deps;

    batch_control control_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .s_valid         (s_valid),
        .s_txn           (s_txn),
        .s_ready         (s_ready),
        .m_valid         (m_valid),
        .m_ready         (m_ready),
        .batch_completed (batch_completed),
        .buf_port        (buf_bus.ctrl)
    );

    batch_buffer buffer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .buf_port (buf_bus.buffer)
    );

    batch_stats stats_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .m_valid              (m_valid),
        .m_ready              (m_ready),
        .batch_completed      (batch_completed),
        .transactions_batched (transactions_batched),
        .batch_stall_count    (batch_stall_count)
    );

endmodule
